/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_udp_ip_tx
FILELIST  = files.f
OBJDIR    = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* files.f */
hw/net_hdr_pkg.sv
hw/tx_if_pkg.sv
hw/net_cfg_regs.sv
hw/udp_tx.sv
hw/ipv4_tx.sv
hw/udp_ip_tx_top.sv
test/tx_monitor.sv
test/tb_udp_ip_tx.sv

/* hw/ipv4_tx.sv */
`timescale 1ns/10ps
`default_nettype none

module ipv4_tx (
  input  logic                  clk,
  input  logic                  fsm_rst,
  input  tx_if_pkg::net_cfg_t   cfg,
  input  logic                  ip_rdy,
  input  tx_if_pkg::ip_meta_t   ip_meta,
  output logic                  udp_req,
  input  tx_if_pkg::byte_strm_t udp_strm,
  output tx_if_pkg::byte_strm_t out_strm
);

  typedef enum logic [1:0] {
    IDLE,
    SUM,
    SEND
  } state_t;

  state_t                 state;
  net_hdr_pkg::ipv4_hdr_u hdr_q;
  logic [15:0]            tot_len_q;
  logic [15:0]            byte_cnt;
  logic [15:0]            id_cnt;
  logic [19:0]            sum_raw;
  logic [16:0]            sum_fold;
  logic [15:0]            csum;
  logic                   sending;
  logic                   hdr_phase;
  logic                   take_meta;
  logic                   frame_clr;

  assign take_meta = (state == IDLE) && ip_rdy;
  assign sending   = (state == SEND);
  assign hdr_phase = byte_cnt < net_hdr_pkg::IPV4_HDR_LEN;
  assign frame_clr = sending && (byte_cnt == tot_len_q - 16'd1);

  // Checksum field is still zero while the words are summed
  always_comb begin
    sum_raw = '0;
    for (int i = 0; i < net_hdr_pkg::IPV4_HDR_WORDS; i++) begin
      sum_raw = sum_raw + {4'h0, hdr_q.w[i]};
    end
    sum_fold = {1'b0, sum_raw[15:0]} + {13'h0, sum_raw[19:16]};
    csum     = ~(sum_fold[15:0] + {15'h0, sum_fold[16]}); // End-around carry
  end

  always_ff @(posedge clk) begin
    if (fsm_rst || frame_clr) begin
      state    <= IDLE;
      byte_cnt <= '0;
    end
    else begin
      case (state)
        IDLE: begin
          if (ip_rdy) begin
            state <= SUM;
          end
        end
        SUM: begin
          state <= SEND;
        end
        SEND: begin
          byte_cnt <= byte_cnt + 16'd1;
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      id_cnt <= '0;
    end
    else if (frame_clr) begin
      id_cnt <= id_cnt + 16'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (take_meta) begin
      hdr_q.f.ver       <= net_hdr_pkg::IPV4_VERSION;
      hdr_q.f.ihl       <= net_hdr_pkg::IPV4_IHL;
      hdr_q.f.tos       <= '0;
      hdr_q.f.total_len <= net_hdr_pkg::IPV4_HDR_LEN + ip_meta.udp_len;
      hdr_q.f.id        <= id_cnt;
      hdr_q.f.flags     <= '0;
      hdr_q.f.frag_ofs  <= '0;
      hdr_q.f.ttl       <= cfg.ttl; // Config is sampled once per frame
      hdr_q.f.proto     <= net_hdr_pkg::IPV4_PROTO_UDP;
      hdr_q.f.checksum  <= '0;
      hdr_q.f.src_ip    <= cfg.local_ip;
      hdr_q.f.dst_ip    <= ip_meta.dst_ip;
      tot_len_q         <= net_hdr_pkg::IPV4_HDR_LEN + ip_meta.udp_len;
    end
    else if (state == SUM) begin
      hdr_q.f.checksum <= csum;
    end
    else if (sending && hdr_phase) begin
      hdr_q.w <= {hdr_q.w[9][7:0], hdr_q.w[8:0], 8'h00};
    end
  end

  // Raised with header byte 19 so the first UDP byte follows without a gap
  assign udp_req = sending
                && (byte_cnt >= net_hdr_pkg::IPV4_HDR_LEN - 16'd1)
                && (byte_cnt < tot_len_q - 16'd1);

  always_comb begin
    out_strm.dat = hdr_phase ? hdr_q.w[9][15:8] : udp_strm.dat;
    out_strm.val = sending;
    out_strm.sof = sending && (byte_cnt == 16'd0);
    out_strm.eof = frame_clr;
  end

  a_udp_byte_follows: assert property (
    @(posedge clk) disable iff (fsm_rst)
    udp_req |=> udp_strm.val
  );

  // The final byte of a frame always comes from the UDP side
  a_eof_val: assert property (
    @(posedge clk) disable iff (fsm_rst)
    out_strm.eof |-> udp_strm.val
  );

endmodule : ipv4_tx

`default_nettype wire

/* hw/net_cfg_regs.sv */
`timescale 1ns/10ps
`default_nettype none

module net_cfg_regs (
  input  logic                clk,
  input  logic                fsm_rst,
  input  logic                cfg_wr,
  input  logic                cfg_addr,
  input  logic [31:0]         cfg_wdata,
  output tx_if_pkg::net_cfg_t cfg
);

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      cfg.local_ip <= '0;
      cfg.ttl      <= net_hdr_pkg::DEFAULT_TTL;
    end
    else if (cfg_wr) begin
      case (cfg_addr)
        tx_if_pkg::CFG_ADDR_IP: begin
          cfg.local_ip <= cfg_wdata;
        end
        tx_if_pkg::CFG_ADDR_TTL: begin
          cfg.ttl <= cfg_wdata[7:0]; // Upper bits are ignored
        end
      endcase
    end
  end

  // A zero TTL would make every router on the path drop the datagram
  a_ttl_nonzero: assert property (
    @(posedge clk) disable iff (fsm_rst)
    (cfg_wr && cfg_addr == tx_if_pkg::CFG_ADDR_TTL) |-> (cfg_wdata[7:0] != 8'd0)
  );

endmodule : net_cfg_regs

`default_nettype wire

/* hw/net_hdr_pkg.sv */
`default_nettype none

package net_hdr_pkg;

  // Lengths are kept 16 bits wide so they compare directly with byte counters
  localparam logic [15:0] UDP_HDR_LEN  = 16'd8;
  localparam logic [15:0] IPV4_HDR_LEN = 16'd20;
  localparam int          IPV4_HDR_WORDS = 10;

  localparam logic [3:0] IPV4_VERSION   = 4'd4;
  localparam logic [3:0] IPV4_IHL       = 4'd5; // No options, so always five words
  localparam logic [7:0] IPV4_PROTO_UDP = 8'd17;
  localparam logic [7:0] DEFAULT_TTL    = 8'd64;

  typedef struct packed {
    logic [15:0] src_port;
    logic [15:0] dst_port;
    logic [15:0] length;   // Header plus payload
    logic [15:0] checksum; // Zero means not computed
  } udp_hdr_t;

  typedef struct packed {
    logic [3:0]  ver;
    logic [3:0]  ihl;
    logic [7:0]  tos;
    logic [15:0] total_len;
    logic [15:0] id;
    logic [2:0]  flags;
    logic [12:0] frag_ofs;
    logic [7:0]  ttl;
    logic [7:0]  proto;
    logic [15:0] checksum;
    logic [31:0] src_ip;
    logic [31:0] dst_ip;
  } ipv4_hdr_t;

  // Word 9 holds version, IHL and TOS; word 4 holds the checksum
  typedef union packed {
    ipv4_hdr_t                             f;
    logic [IPV4_HDR_WORDS-1:0][15:0]       w;
  } ipv4_hdr_u;

endpackage : net_hdr_pkg

`default_nettype wire

/* hw/tx_if_pkg.sv */
`default_nettype none

package tx_if_pkg;

  typedef struct packed {
    logic [7:0] dat;
    logic       val;
    logic       sof;
    logic       eof;
  } byte_strm_t;

  typedef struct packed {
    logic [15:0] src_port;
    logic [15:0] dst_port;
    logic [31:0] dst_ip;
    logic [15:0] pld_len; // Never zero
  } udp_meta_t;

  typedef struct packed {
    logic [31:0] dst_ip;
    logic [15:0] udp_len; // Includes the UDP header
  } ip_meta_t;

  typedef struct packed {
    logic [31:0] local_ip;
    logic [7:0]  ttl;
  } net_cfg_t;

  localparam logic CFG_ADDR_IP  = 1'b0;
  localparam logic CFG_ADDR_TTL = 1'b1;

endpackage : tx_if_pkg

`default_nettype wire

/* hw/udp_ip_tx_top.sv */
`timescale 1ns/10ps
`default_nettype none

module udp_ip_tx_top (
  input  logic                  clk,
  input  logic                  fsm_rst,
  input  logic                  cfg_wr,
  input  logic                  cfg_addr,
  input  logic [31:0]           cfg_wdata,
  input  logic                  app_rdy,
  input  tx_if_pkg::udp_meta_t  app_meta,
  output logic                  app_req,
  input  logic [7:0]            app_dat,
  output tx_if_pkg::byte_strm_t out_strm
);

  tx_if_pkg::net_cfg_t   cfg;
  tx_if_pkg::ip_meta_t   ip_meta;
  tx_if_pkg::byte_strm_t udp_strm;
  logic                  ip_rdy;
  logic                  udp_req;

  net_cfg_regs u_cfg (
    .clk       (clk),
    .fsm_rst   (fsm_rst),
    .cfg_wr    (cfg_wr),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .cfg       (cfg)
  );

  udp_tx u_udp (
    .clk      (clk),
    .fsm_rst  (fsm_rst),
    .app_rdy  (app_rdy),
    .app_meta (app_meta),
    .app_req  (app_req),
    .app_dat  (app_dat),
    .ip_rdy   (ip_rdy),
    .ip_meta  (ip_meta),
    .udp_req  (udp_req),
    .udp_strm (udp_strm)
  );

  ipv4_tx u_ipv4 (
    .clk      (clk),
    .fsm_rst  (fsm_rst),
    .cfg      (cfg),
    .ip_rdy   (ip_rdy),
    .ip_meta  (ip_meta),
    .udp_req  (udp_req),
    .udp_strm (udp_strm),
    .out_strm (out_strm)
  );

endmodule : udp_ip_tx_top

`default_nettype wire

/* hw/udp_tx.sv */
`timescale 1ns/10ps
`default_nettype none

module udp_tx (
  input  logic                  clk,
  input  logic                  fsm_rst,
  input  logic                  app_rdy,
  input  tx_if_pkg::udp_meta_t  app_meta,
  output logic                  app_req,
  input  logic [7:0]            app_dat,
  output logic                  ip_rdy,
  output tx_if_pkg::ip_meta_t   ip_meta,
  input  logic                  udp_req,
  output tx_if_pkg::byte_strm_t udp_strm
);

  net_hdr_pkg::udp_hdr_t                     hdr_new;
  logic [net_hdr_pkg::UDP_HDR_LEN-1:0][7:0]  hdr_sr;
  logic [15:0]                               byte_cnt;
  logic                                      val_q;
  logic                                      hdr_phase;
  logic                                      take_meta;
  logic                                      frame_clr;

  // ip_rdy doubles as the busy flag of this block
  assign take_meta = app_rdy && !ip_rdy;
  assign hdr_phase = byte_cnt < net_hdr_pkg::UDP_HDR_LEN;
  assign frame_clr = val_q && (byte_cnt == ip_meta.udp_len - 16'd1); // Last UDP byte

  always_comb begin
    hdr_new.src_port = app_meta.src_port;
    hdr_new.dst_port = app_meta.dst_port;
    hdr_new.length   = net_hdr_pkg::UDP_HDR_LEN + app_meta.pld_len;
    hdr_new.checksum = '0;
  end

  always_ff @(posedge clk) begin
    if (fsm_rst || frame_clr) begin
      ip_rdy   <= 1'b0;
      val_q    <= 1'b0;
      byte_cnt <= '0;
    end
    else begin
      val_q <= udp_req; // One byte follows every request cycle
      if (val_q) begin
        byte_cnt <= byte_cnt + 16'd1;
      end
      if (take_meta) begin
        ip_rdy <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take_meta) begin
      hdr_sr          <= hdr_new;
      ip_meta.dst_ip  <= app_meta.dst_ip;
      ip_meta.udp_len <= hdr_new.length;
    end
    else if (val_q && hdr_phase) begin
      hdr_sr <= {hdr_sr[net_hdr_pkg::UDP_HDR_LEN-2:0], 8'h00}; // MSB first
    end
  end

  // Requested while header byte 7 goes out, so payload byte 0 lands right after it
  assign app_req = val_q
                && (byte_cnt >= net_hdr_pkg::UDP_HDR_LEN - 16'd1)
                && (byte_cnt < ip_meta.udp_len - 16'd1);

  always_comb begin
    udp_strm.dat = hdr_phase ? hdr_sr[net_hdr_pkg::UDP_HDR_LEN-1] : app_dat;
    udp_strm.val = val_q;
    udp_strm.sof = 1'b0; // Framing marks are added by the IPv4 side
    udp_strm.eof = 1'b0;
  end

  // Payload requests only happen while the IPv4 side holds the frame open
  a_req_in_frame: assert property (
    @(posedge clk) disable iff (fsm_rst)
    app_req |-> ip_rdy
  );

  // A held app_rdy would start the same datagram again once this block is idle
  a_rdy_dropped: assert property (
    @(posedge clk) disable iff (fsm_rst)
    app_req |=> !app_rdy
  );

endmodule : udp_tx

`default_nettype wire

/* test/tb_udp_ip_tx.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_udp_ip_tx;

  localparam int REQ_TMO = 64;
  localparam int EOF_TMO = 128;

  logic                  clk;
  logic                  fsm_rst;
  logic                  cfg_wr;
  logic                  cfg_addr;
  logic [31:0]           cfg_wdata;
  logic                  app_rdy;
  tx_if_pkg::udp_meta_t  app_meta;
  logic                  app_req;
  logic [7:0]            app_dat;
  tx_if_pkg::byte_strm_t out_strm;
  logic                  ck_stb;
  logic [15:0]           ck_val;

  int                    val_errs;
  int                    proto_errs;
  int                    frames_seen;
  int                    frames_sent;
  int                    timeouts;
  int                    stim_errs;
  int                    fd;
  int                    rc;
  logic [7:0]            tag;
  logic [8*128-1:0]      line;
  logic [31:0]           f_addr;
  logic [31:0]           f_data;
  logic [15:0]           f_sp;
  logic [15:0]           f_dp;
  logic [31:0]           f_ip;
  logic [15:0]           f_len;
  logic [15:0]           f_ck;
  logic [7:0]            pld [0:255];

  udp_ip_tx_top uut (
    .clk       (clk),
    .fsm_rst   (fsm_rst),
    .cfg_wr    (cfg_wr),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .app_rdy   (app_rdy),
    .app_meta  (app_meta),
    .app_req   (app_req),
    .app_dat   (app_dat),
    .out_strm  (out_strm)
  );

  tx_monitor u_mon (
    .clk        (clk),
    .fsm_rst    (fsm_rst),
    .cfg_wr     (cfg_wr),
    .cfg_addr   (cfg_addr),
    .cfg_wdata  (cfg_wdata),
    .app_rdy    (app_rdy),
    .app_meta   (app_meta),
    .app_req    (app_req),
    .app_dat    (app_dat),
    .out_strm   (out_strm),
    .ck_stb     (ck_stb),
    .ck_val     (ck_val),
    .val_errs   (val_errs),
    .proto_errs (proto_errs),
    .frames     (frames_seen)
  );

  always #50 clk = ~clk;

  task automatic cfg_write(input logic addr, input logic [31:0] data);
    @(posedge clk);
    cfg_wr    <= 1'b1;
    cfg_addr  <= addr;
    cfg_wdata <= data;
    @(posedge clk);
    cfg_wr    <= 1'b0;
  endtask

  task automatic send_frame();
    int n;
    int t;
    logic seen;
    n    = 0;
    t    = 0;
    seen = 1'b0;
    @(posedge clk);
    app_meta <= '{src_port: f_sp, dst_port: f_dp, dst_ip: f_ip, pld_len: f_len};
    app_rdy  <= 1'b1;
    ck_stb   <= 1'b1; // Expected checksum goes to the monitor with the meta
    ck_val   <= f_ck;
    while (!seen && t < REQ_TMO) begin
      @(posedge clk);
      ck_stb <= 1'b0;
      if (app_req) begin
        app_rdy <= 1'b0;
        app_dat <= pld[n];
        n++;
        seen = 1'b1;
      end
      t++;
    end
    if (!seen) begin
      $display("timeout: app_req never rose for datagram %0d", frames_sent);
      timeouts++;
      return;
    end
    t    = 0;
    seen = 1'b0;
    while (!seen && t < EOF_TMO + int'(f_len)) begin
      @(posedge clk);
      if (out_strm.eof) begin
        seen = 1'b1;
      end
      else if (app_req) begin
        app_dat <= pld[n];
        n++;
      end
      t++;
    end
    if (!seen) begin
      $display("timeout: no end of frame for datagram %0d", frames_sent);
      timeouts++;
    end
  endtask

  initial begin
    clk         = 1'b0;
    fsm_rst     = 1'b1;
    cfg_wr      = 1'b0;
    cfg_addr    = 1'b0;
    cfg_wdata   = '0;
    app_rdy     = 1'b0;
    app_meta    = '0;
    app_dat     = '0;
    ck_stb      = 1'b0;
    ck_val      = '0;
    frames_sent = 0;
    timeouts    = 0;
    stim_errs   = 0;
    repeat (4) @(posedge clk);
    fsm_rst <= 1'b0;

    fd = $fopen("test/tx_stim.txt", "r");
    if (fd == 0) begin
      $display("the stimulus file test/tx_stim.txt could not be opened");
      stim_errs++;
    end
    else begin
      while (timeouts == 0 && $fscanf(fd, " %c", tag) == 1) begin
        if (tag == "#") begin
          rc = $fgets(line, fd);
        end
        else if (tag == "C") begin
          rc = $fscanf(fd, "%h %h", f_addr, f_data);
          cfg_write(f_addr[0], f_data);
        end
        else if (tag == "F") begin
          rc = $fscanf(fd, "%h %h %h %h %h", f_sp, f_dp, f_ip, f_len, f_ck);
          for (int i = 0; i < int'(f_len); i++) begin
            rc = $fscanf(fd, "%h", pld[i]);
          end
          send_frame();
          frames_sent++;
        end
        else begin
          $display("the stimulus file holds a line of unknown type");
          stim_errs++;
        end
      end
      $fclose(fd);
    end

    repeat (5) @(posedge clk);
    if (frames_seen != frames_sent) begin
      $display("%0d datagrams were sent but %0d frames came out", frames_sent, frames_seen);
      stim_errs++;
    end
    $display("errors: value %0d protocol %0d timeout %0d other %0d",
             val_errs, proto_errs, timeouts, stim_errs);
    if (val_errs == 0 && proto_errs == 0 && timeouts == 0 && stim_errs == 0) begin
      $display("TEST PASS");
    end
    else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule : tb_udp_ip_tx

`default_nettype wire

/* test/tx_monitor.sv */
`timescale 1ns/10ps
`default_nettype none

module tx_monitor (
  input  logic                  clk,
  input  logic                  fsm_rst,
  input  logic                  cfg_wr,
  input  logic                  cfg_addr,
  input  logic [31:0]           cfg_wdata,
  input  logic                  app_rdy,
  input  tx_if_pkg::udp_meta_t  app_meta,
  input  logic                  app_req,
  input  logic [7:0]            app_dat,
  input  tx_if_pkg::byte_strm_t out_strm,
  input  logic                  ck_stb,
  input  logic [15:0]           ck_val,
  output int                    val_errs,
  output int                    proto_errs,
  output int                    frames
);

  logic [31:0]          ip_m;
  logic [7:0]           ttl_m;
  logic [15:0]          id_m;
  logic [15:0]          ck_file;
  logic [15:0]          ck_calc;
  tx_if_pkg::udp_meta_t meta_q;
  logic [7:0]           exp_hdr [0:27];
  logic [7:0]           pld_q [$];
  logic [7:0]           exp_b;
  logic                 idle;
  logic                 req_d;
  int                   cyc;
  int                   idx;
  int                   last_idx;
  int                   req_cnt;

  task automatic value_error(input string name, input logic [15:0] exp, input logic [15:0] act);
    $display("error at %0d ns: %s expected %0h actual %0h", $time, name, exp, act);
    val_errs++;
  endtask

  task automatic protocol_error(input string msg);
    $display("at %0d ns %s", $time, msg);
    proto_errs++;
  endtask

  // Ones' complement sum over the ten header words, checksum field taken as zero
  function automatic logic [15:0] header_checksum();
    logic [31:0] s;
    s = 0;
    for (int i = 0; i < 20; i += 2) begin
      if (i != 10) begin
        s = s + {16'h0, exp_hdr[i], exp_hdr[i+1]};
      end
    end
    while (s[31:16] != 0) begin
      s = {16'h0, s[15:0]} + {16'h0, s[31:16]};
    end
    return ~s[15:0];
  endfunction

  task automatic build_frame_header();
    logic [15:0] udp_len;
    logic [15:0] tot_len;
    udp_len = 16'd8 + meta_q.pld_len;
    tot_len = 16'd20 + udp_len;
    exp_hdr = '{8'h45, 8'h00, tot_len[15:8], tot_len[7:0], id_m[15:8], id_m[7:0],
                8'h00, 8'h00, ttl_m, 8'd17, 8'h00, 8'h00,
                ip_m[31:24], ip_m[23:16], ip_m[15:8], ip_m[7:0],
                meta_q.dst_ip[31:24], meta_q.dst_ip[23:16],
                meta_q.dst_ip[15:8], meta_q.dst_ip[7:0],
                meta_q.src_port[15:8], meta_q.src_port[7:0],
                meta_q.dst_port[15:8], meta_q.dst_port[7:0],
                udp_len[15:8], udp_len[7:0], 8'h00, 8'h00};
    ck_calc     = header_checksum();
    exp_hdr[10] = ck_calc[15:8];
    exp_hdr[11] = ck_calc[7:0];
    if (ck_calc != ck_file) begin
      value_error("ipv4 checksum from stim file", ck_file, ck_calc);
    end
    last_idx = 27 + int'(meta_q.pld_len);
  endtask

  always @(posedge clk) begin
    if (fsm_rst) begin
      ip_m       = '0;
      ttl_m      = 8'd64;
      id_m       = '0;
      idle       = 1'b1;
      req_d      = 1'b0;
      val_errs   = 0;
      proto_errs = 0;
      frames     = 0;
      pld_q.delete();
    end
    else begin
      if (req_d) begin
        pld_q.push_back(app_dat); // Byte requested in the previous cycle
      end
      if (ck_stb) begin
        ck_file = ck_val;
      end
      if (idle && ({app_req, out_strm.val, out_strm.sof, out_strm.eof} !== 4'b0000)) begin
        protocol_error("DUT is active while no datagram is pending");
      end
      if (!out_strm.val && (out_strm.sof || out_strm.eof)) begin
        protocol_error("sof or eof is set without val");
      end
      if (!idle) begin
        cyc++;
        if (out_strm.val) begin
          if (idx == 0 && (!out_strm.sof || cyc != 3)) begin
            protocol_error("first byte is not marked sof three cycles after app_rdy");
          end
          if (idx != 0 && out_strm.sof) begin
            protocol_error("sof appears inside a frame");
          end
          if (idx < 28) begin
            exp_b = exp_hdr[idx];
          end
          else if (pld_q.size() > idx - 28) begin
            exp_b = pld_q[idx-28];
          end
          else begin
            exp_b = 8'hxx;
            protocol_error("payload byte sent before it was requested");
          end
          if (out_strm.dat !== exp_b) begin
            value_error($sformatf("out_strm.dat byte %0d", idx), exp_b, out_strm.dat);
          end
          if (out_strm.eof != (idx == last_idx)) begin
            value_error($sformatf("out_strm.eof byte %0d", idx), idx == last_idx, out_strm.eof);
          end
          if (out_strm.eof || idx == last_idx) begin
            if (req_cnt != int'(meta_q.pld_len)) begin
              value_error("app_req cycles", meta_q.pld_len, req_cnt);
            end
            idle = 1'b1;
            frames++;
            id_m++;
          end
          idx++;
        end
        else if (idx > 0) begin
          protocol_error("gap inside a frame");
        end
        else if (cyc == 4) begin
          protocol_error("frame did not start three cycles after app_rdy");
        end
      end
      if (app_req) begin
        req_cnt++;
      end
      req_d = app_req;
      if (cfg_wr) begin
        if (cfg_addr) begin
          ttl_m = cfg_wdata[7:0];
        end
        else begin
          ip_m = cfg_wdata;
        end
      end
      if (idle && app_rdy && !out_strm.eof) begin
        meta_q  = app_meta;
        idle    = 1'b0;
        cyc     = 0;
        idx     = 0;
        req_cnt = 0;
        pld_q.delete();
        build_frame_header();
      end
    end
  end

endmodule : tx_monitor

`default_nettype wire

/* test/tx_stim.txt */
# C reg_addr data (hex)
# F src_port dst_port dst_ip pld_len ipv4_checksum (hex), then pld_len payload bytes
F 1234 0050 C0A80102 4 B923
11 22 33 44
C 0 0A000001
C 1 00000020
F 4000 0035 0A0000FE 1 85D1
A5
F ABCD 1F90 C0A80001 6 D01F
01 02 03 04 05 06
C 1 FFFFFF80
F 0007 0009 7F000001 3 B1C9
DE AD BE
